// ==== sim.f ====
+incdir+source
source/frv_isa_pkg.sv
source/frv_pipe_pkg.sv
source/frv_stage_if.sv
source/frv_gprs.sv
source/frv_pipeline_decode.sv
source/frv_pipeline_execute.sv
source/frv_pipeline_writeback.sv
source/frv_pipeline.sv
tests/tb_frv_pipeline.sv

// ==== Bender.yml ====
package:
  name: frv_pipeline

sources:
  - include_dirs:
      - source
    files:
      - source/frv_isa_pkg.sv
      - source/frv_pipe_pkg.sv
      - source/frv_stage_if.sv
      - source/frv_gprs.sv
      - source/frv_pipeline_decode.sv
      - source/frv_pipeline_execute.sv
      - source/frv_pipeline_writeback.sv
      - source/frv_pipeline.sv
  - target: test
    files:
      - tests/tb_frv_pipeline.sv

// ==== tests/tb_frv_pipeline.sv ====
//--------------------------------------------------------------------------
// Testbench for the three-stage integer pipeline
// Clock, reset, stimulus table, in-order retirement checker and report
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_frv_pipeline;

    logic        g_clk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic        trs_valid;
    logic [31:0] trs_instr;
    logic        trs_trap;
    logic [4:0]  trs_rd;
    logic [31:0] trs_wdata;

    string       names       [64];  // Stimulus table
    logic [31:0] words       [64];
    bit          exp_trap    [64];
    logic [4:0]  exp_rd      [64];
    logic [31:0] exp_wdata   [64];
    bit          gap_after   [64];  // Idle cycles follow this entry
    int          issue_cycle [64];
    int          n_entries = 0;
    int          n_issued  = 0;
    int          n_passed  = 0;
    int          errors    = 0;
    int          cycle     = 0;     // Rising edges seen
    integer      seed;

    frv_pipeline dut0 (
        .g_clk       (g_clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .trs_valid   (trs_valid),
        .trs_instr   (trs_instr),
        .trs_trap    (trs_trap),
        .trs_rd      (trs_rd),
        .trs_wdata   (trs_wdata)
    );

    always #2 g_clk = ~g_clk;                    // 4 ns period
    always @(posedge g_clk) cycle <= cycle + 1;

    // ----------------------------------------------------------------------
    // Instruction encoders
    function automatic logic [31:0] imm_word(logic [11:0] imm, logic [4:0] rs1,
                                             logic [2:0] f3, logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};   // OP-IMM
    endfunction

    function automatic logic [31:0] reg_word(logic [6:0] f7, logic [4:0] rs2,
                                             logic [4:0] rs1, logic [2:0] f3,
                                             logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};  // OP
    endfunction

    function automatic logic [31:0] lui_word(logic [19:0] imm, logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic void add_entry(string name, logic [31:0] word, bit trap,
                                      logic [4:0] rd, logic [31:0] wdata);
        names[n_entries]     = name;
        words[n_entries]     = word;
        exp_trap[n_entries]  = trap;
        exp_rd[n_entries]    = rd;
        exp_wdata[n_entries] = wdata;
        gap_after[n_entries] = 1'b0;
        n_entries++;
    endfunction

    function automatic void end_group();
        gap_after[n_entries-1] = 1'b1;
    endfunction

    // ----------------------------------------------------------------------
    // Expected values worked out by hand, registers start at zero
    function automatic void build_table();
        add_entry("addi_pos",     imm_word(12'd5,   0, 0, 1),  0, 1,  32'h00000005);
        add_entry("addi_neg",     imm_word(12'hffd, 0, 0, 2),  0, 2,  32'hfffffffd);
        add_entry("slti_neg",     imm_word(12'd1,   2, 2, 3),  0, 3,  32'h00000001);
        add_entry("sltiu_big",    imm_word(12'd1,   2, 3, 4),  0, 4,  32'h00000000);
        add_entry("xori",         imm_word(12'h00f, 1, 4, 5),  0, 5,  32'h0000000a);
        add_entry("ori",          imm_word(12'h030, 1, 6, 6),  0, 6,  32'h00000035);
        add_entry("andi",         imm_word(12'h0f0, 2, 7, 7),  0, 7,  32'h000000f0);
        add_entry("slli",         imm_word(12'd4,   1, 1, 8),  0, 8,  32'h00000050);
        add_entry("srli_neg",     imm_word(12'd28,  2, 5, 9),  0, 9,  32'h0000000f);
        add_entry("srai_neg",     imm_word(12'h401, 2, 5, 10), 0, 10, 32'hfffffffe);
        end_group();
        add_entry("add",          reg_word(7'h00, 5,  1,  0, 11), 0, 11, 32'h0000000f);
        add_entry("sub_neg",      reg_word(7'h20, 5,  1,  0, 12), 0, 12, 32'hfffffffb);
        add_entry("sll",          reg_word(7'h00, 9,  1,  1, 13), 0, 13, 32'h00028000);
        add_entry("slt_signed",   reg_word(7'h00, 1,  2,  2, 14), 0, 14, 32'h00000001);
        add_entry("sltu_unsign",  reg_word(7'h00, 1,  2,  3, 15), 0, 15, 32'h00000000);
        add_entry("xor",          reg_word(7'h00, 7,  6,  4, 16), 0, 16, 32'h000000c5);
        add_entry("or",           reg_word(7'h00, 8,  5,  6, 17), 0, 17, 32'h0000005a);
        add_entry("and",          reg_word(7'h00, 16, 12, 7, 18), 0, 18, 32'h000000c1);
        add_entry("srl_neg",      reg_word(7'h00, 3,  12, 5, 19), 0, 19, 32'h7ffffffd);
        add_entry("sra_neg",      reg_word(7'h20, 3,  12, 5, 20), 0, 20, 32'hfffffffd);
        end_group();
        add_entry("chain_seed",   imm_word(12'd1, 0, 0, 21),      0, 21, 32'h00000001);
        add_entry("chain_ex_fwd", reg_word(7'h00, 21, 21, 0, 21), 0, 21, 32'h00000002);
        add_entry("chain_dbl",    reg_word(7'h00, 21, 21, 0, 22), 0, 22, 32'h00000004);
        add_entry("chain_wb_fwd", reg_word(7'h00, 22, 21, 0, 21), 0, 21, 32'h00000006);
        add_entry("chain_sub",    reg_word(7'h20, 21, 22, 0, 23), 0, 23, 32'hfffffffe);
        add_entry("chain_slli",   imm_word(12'd3, 23, 1, 23),     0, 23, 32'hfffffff0);
        add_entry("chain_xor",    reg_word(7'h00, 21, 23, 4, 24), 0, 24, 32'hfffffff6);
        end_group();
        add_entry("lui",          lui_word(20'h12345, 25),        0, 25, 32'h12345000);
        add_entry("lui_addi",     imm_word(12'h678, 25, 0, 25),   0, 25, 32'h12345678);
        add_entry("addi_to_x0",   imm_word(12'd7, 1, 0, 0),       0, 0,  32'h00000000);
        add_entry("read_x0",      reg_word(7'h00, 25, 0, 0, 26),  0, 26, 32'h12345678);
        add_entry("lui_top",      lui_word(20'hfffff, 27),        0, 27, 32'hfffff000);
        end_group();
        add_entry("ill_zero",     32'h00000000,                   1, 0,  32'h00000000);
        add_entry("ill_ones",     32'hffffffff,                   1, 0,  32'h00000000);
        add_entry("ill_load_x1",  32'h00002083,                   1, 0,  32'h00000000);
        add_entry("ill_f7_x5",    reg_word(7'h20, 1, 1, 4, 5),    1, 0,  32'h00000000);
        add_entry("x1_kept",      reg_word(7'h00, 0, 1, 0, 29),   0, 29, 32'h00000005);
        add_entry("x5_kept",      imm_word(12'd0, 5, 0, 30),      0, 30, 32'h0000000a);
    endfunction

    // ----------------------------------------------------------------------
    // Driver, one entry per cycle, random idle gap after each group
    task automatic drive_table();
        int gap;
        for (int i = 0; i < n_entries; i++) begin
            @(posedge g_clk);
            #1;
            instr_valid    = 1'b1;
            instr          = words[i];
            issue_cycle[i] = cycle;               // Sampled at the next edge
            n_issued++;
            if (gap_after[i]) begin
                gap = 1 + ($unsigned($random(seed)) % 2);  // 1 or 2 idle cycles
                @(posedge g_clk);
                #1;
                instr_valid = 1'b0;
                instr       = '0;
                repeat (gap - 1) begin
                    @(posedge g_clk);
                    #1;
                end
            end
        end
        @(posedge g_clk);
        #1;
        instr_valid = 1'b0;
        instr       = '0;
    endtask

    // Compare one retirement against table entry i
    task automatic check_entry(input int i);
        int errs_before;
        errs_before = errors;
        assert (i < n_issued) else begin
            $display("Entry %s retired before it was issued", names[i]);
            errors++;
        end
        assert (cycle == issue_cycle[i] + 3) else begin
            $display("Wrong latency for %s, issued in cycle %0d, retired in cycle %0d",
                     names[i], issue_cycle[i], cycle);
            errors++;
        end
        assert (trs_instr === words[i]) else begin
            $display("Mismatch %s instr: expected %h, actual %h", names[i], words[i],
                     trs_instr);
            errors++;
        end
        assert (trs_trap === exp_trap[i]) else begin
            $display("Mismatch %s trap: expected %0b, actual %0b", names[i], exp_trap[i],
                     trs_trap);
            errors++;
        end
        assert (trs_rd === exp_rd[i]) else begin
            $display("Mismatch %s rd: expected %0d, actual %0d", names[i], exp_rd[i], trs_rd);
            errors++;
        end
        assert (trs_wdata === exp_wdata[i]) else begin
            $display("Mismatch %s wdata: expected %h, actual %h", names[i], exp_wdata[i],
                     trs_wdata);
            errors++;
        end
        if (errors == errs_before) begin
            n_passed++;
            $display("ok      %s", names[i]);
        end else begin
            $display("FAILED  %s", names[i]);
        end
    endtask

    // Checker, samples on the falling edge where outputs are settled
    task automatic check_retirements();
        int idx;
        int wait_cycles;
        bit timed_out;
        idx       = 0;
        timed_out = 1'b0;
        while (idx < n_entries && !timed_out) begin
            wait_cycles = 0;
            @(negedge g_clk);
            while (!trs_valid && wait_cycles < 20) begin
                wait_cycles++;
                @(negedge g_clk);
            end
            if (!trs_valid) begin
                $display("Timeout: %s did not retire within 20 cycles", names[idx]);
                errors++;
                timed_out = 1'b1;
            end else begin
                check_entry(idx);
                idx++;
            end
        end
        // Pipeline must drain quietly
        for (int k = 0; k < 6 && !timed_out; k++) begin
            @(negedge g_clk);
            assert (!trs_valid) else begin
                $display("Unexpected retirement after the last instruction");
                errors++;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    initial begin
        seed        = 32'he1a0850c;
        g_clk       = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        build_table();
        repeat (2) @(posedge g_clk);              // Reset for 2 cycles
        #1;
        rst_n = 1'b1;
        fork
            drive_table();
            check_retirements();
        join
        $display("Entries: %0d, passed: %0d, failed: %0d, errors: %0d",
                 n_entries, n_passed, n_entries - n_passed, errors);
        if (errors == 0 && n_passed == n_entries) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== source/frv_pipeline.sv ====
//--------------------------------------------------------------------------
// Pipeline top level
// Decode, execute and writeback stages around the register file
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module frv_pipeline (
    input  logic                    g_clk,        // Core clock
    input  logic                    rst_n,
    input  logic                    instr_valid,  // One word per strobe
    input  frv_isa_pkg::instr_t     instr,
    output logic                    trs_valid,    // Retirement trace
    output frv_isa_pkg::instr_t     trs_instr,
    output logic                    trs_trap,
    output frv_pipe_pkg::reg_addr_t trs_rd,
    output frv_pipe_pkg::xword_t    trs_wdata
);
    import frv_pipe_pkg::*;

    reg_addr_t rs1_addr;       // Decode read addresses
    reg_addr_t rs2_addr;
    xword_t    rs1_rdata;      // Register file read data
    xword_t    rs2_rdata;
    reg_addr_t fwd_s2_rd;      // Execute forwarding tap
    xword_t    fwd_s2_wdata;
    logic      gpr_wen;        // Writeback write port
    reg_addr_t gpr_rd;
    xword_t    gpr_wdata;

    frv_s2_if s2_if ();        // Decode to execute
    frv_s3_if s3_if ();        // Execute to writeback

    frv_pipeline_decode i_pipeline_s1_decode (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rs1_rdata    (rs1_rdata),
        .rs2_rdata    (rs2_rdata),
        .fwd_s2_rd    (fwd_s2_rd),
        .fwd_s2_wdata (fwd_s2_wdata),
        .gpr_wen      (gpr_wen),
        .gpr_rd       (gpr_rd),
        .gpr_wdata    (gpr_wdata),
        .s2           (s2_if.src)
    );

    frv_pipeline_execute i_pipeline_s2_execute (
        .g_clk        (g_clk),
        .rst_n        (rst_n),
        .s2           (s2_if.dst),
        .fwd_s2_rd    (fwd_s2_rd),
        .fwd_s2_wdata (fwd_s2_wdata),
        .s3           (s3_if.src)
    );

    frv_pipeline_writeback i_pipeline_s3_writeback (
        .g_clk     (g_clk),
        .rst_n     (rst_n),
        .s3        (s3_if.dst),
        .gpr_wen   (gpr_wen),
        .gpr_rd    (gpr_rd),
        .gpr_wdata (gpr_wdata),
        .trs_valid (trs_valid),
        .trs_instr (trs_instr),
        .trs_trap  (trs_trap),
        .trs_rd    (trs_rd),
        .trs_wdata (trs_wdata)
    );

    frv_gprs i_gprs (
        .g_clk    (g_clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs1_data (rs1_rdata),
        .rs2_addr (rs2_addr),
        .rs2_data (rs2_rdata),
        .rd_wen   (gpr_wen),
        .rd_addr  (gpr_rd),
        .rd_data  (gpr_wdata)
    );

endmodule

// ==== source/frv_pipeline_writeback.sv ====
//--------------------------------------------------------------------------
// Writeback stage
// Register file write port and registered retirement trace
//--------------------------------------------------------------------------

`timescale 1ns/1ps

module frv_pipeline_writeback (
    input  logic                    g_clk,
    input  logic                    rst_n,
    frv_s3_if.dst                   s3,
    output logic                    gpr_wen,    // GPR write enable
    output frv_pipe_pkg::reg_addr_t gpr_rd,     // GPR destination
    output frv_pipe_pkg::xword_t    gpr_wdata,  // GPR write data
    output logic                    trs_valid,  // One cycle per retirement
    output frv_isa_pkg::instr_t     trs_instr,
    output logic                    trs_trap,
    output frv_pipe_pkg::reg_addr_t trs_rd,
    output frv_pipe_pkg::xword_t    trs_wdata
);

    // Write only real results and never x0
    assign gpr_wen   = s3.valid && !s3.trap && (s3.rd != '0);
    assign gpr_rd    = s3.rd;
    assign gpr_wdata = s3.result;

    // ----------------------------------------------------------------------
    // Trace register loaded at the same edge as the GPR write
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            trs_valid <= 1'b0;
        end else begin
            trs_valid <= s3.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s3.valid) begin
            trs_instr <= s3.instr;
            trs_trap  <= s3.trap;
            trs_rd    <= s3.rd;  // Decode clears rd on trap
            // Shows zero whenever nothing is written, on trap or x0
            trs_wdata <= gpr_wen ? s3.result : '0;
        end
    end

endmodule

// ==== source/frv_pipeline_execute.sv ====
//--------------------------------------------------------------------------
// Execute stage
// ALU, forwarding tap and execute-to-writeback register
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_pipeline_execute (
    input  logic                    g_clk,
    input  logic                    rst_n,
    frv_s2_if.dst                   s2,
    output frv_pipe_pkg::reg_addr_t fwd_s2_rd,     // Zero unless result is live
    output frv_pipe_pkg::xword_t    fwd_s2_wdata,  // Combinational ALU result
    frv_s3_if.src                   s3
);
    import frv_pipe_pkg::*;

    xword_t     alu_result;
    logic [4:0] shamt;

    assign shamt = s2.opr_b[4:0];  // RV32 shifts use 5 bits

    always_comb begin
        case (s2.uop)
            UOP_ADD:    alu_result = s2.opr_a + s2.opr_b;
            UOP_SUB:    alu_result = s2.opr_a - s2.opr_b;
            UOP_SLL:    alu_result = s2.opr_a << shamt;
            UOP_SLT:    alu_result = xword_t'($signed(s2.opr_a) < $signed(s2.opr_b));
            UOP_SLTU:   alu_result = xword_t'(s2.opr_a < s2.opr_b);
            UOP_XOR:    alu_result = s2.opr_a ^ s2.opr_b;
            UOP_SRL:    alu_result = s2.opr_a >> shamt;
            UOP_SRA:    alu_result = $signed(s2.opr_a) >>> shamt;  // Sign fill
            UOP_OR:     alu_result = s2.opr_a | s2.opr_b;
            UOP_AND:    alu_result = s2.opr_a & s2.opr_b;
            UOP_PASS_B: alu_result = s2.opr_b;                     // LUI
            default:    alu_result = '0;
        endcase
    end

    // Tap for the instruction now in decode
    assign fwd_s2_rd    = (s2.valid && !s2.trap) ? s2.rd : '0;
    assign fwd_s2_wdata = alu_result;

    // ----------------------------------------------------------------------
    // Execute-to-writeback register
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s3.valid <= 1'b0;
        end else begin
            s3.valid <= s2.valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (s2.valid) begin
            s3.rd     <= s2.rd;
            s3.result <= alu_result;
            s3.trap   <= s2.trap;
            s3.instr  <= s2.instr;
        end
    end

    // Decode clears rd for every trapping word
    a_trap_no_rd: assert property (@(posedge g_clk) disable iff (!rst_n)
        (s2.valid && s2.trap) |-> s2.rd == '0)
        else $error("Trapping instruction carries a destination register");

endmodule

// ==== source/frv_pipeline_decode.sv ====
//--------------------------------------------------------------------------
// Decode stage
// Opcode/funct3 decode, operand forwarding, decode-to-execute register
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_pipeline_decode (
    input  logic                    g_clk,
    input  logic                    rst_n,
    input  logic                    instr_valid,   // Input strobe
    input  frv_isa_pkg::instr_t     instr,
    output frv_pipe_pkg::reg_addr_t rs1_addr,      // To register file
    output frv_pipe_pkg::reg_addr_t rs2_addr,
    input  frv_pipe_pkg::xword_t    rs1_rdata,
    input  frv_pipe_pkg::xword_t    rs2_rdata,
    input  frv_pipe_pkg::reg_addr_t fwd_s2_rd,     // Execute tap, zero when empty
    input  frv_pipe_pkg::xword_t    fwd_s2_wdata,
    input  logic                    gpr_wen,       // Writeback tap
    input  frv_pipe_pkg::reg_addr_t gpr_rd,
    input  frv_pipe_pkg::xword_t    gpr_wdata,
    frv_s2_if.src                   s2
);
    import frv_isa_pkg::*;
    import frv_pipe_pkg::*;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // Normal ALU op
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // sub / sra

    opcode_t    opcode;
    alu_f3_t    funct3;
    logic [6:0] funct7;
    xword_t     imm_i, imm_u, shamt;
    logic       hzd_rs1_s2, hzd_rs1_wb, hzd_rs2_s2, hzd_rs2_wb;
    xword_t     fwd_rs1_rdata, fwd_rs2_rdata;
    uop_t       dec_uop;
    xword_t     dec_opr_b;
    logic       dec_legal;

    // funct3 to micro-op, alt selects sub / sra
    function automatic uop_t alu_uop(alu_f3_t f3, logic alt);
        case (f3)
            F3_ADD:  alu_uop = alt ? UOP_SUB : UOP_ADD;
            F3_SLL:  alu_uop = UOP_SLL;
            F3_SLT:  alu_uop = UOP_SLT;
            F3_SLTU: alu_uop = UOP_SLTU;
            F3_XOR:  alu_uop = UOP_XOR;
            F3_SR:   alu_uop = alt ? UOP_SRA : UOP_SRL;
            F3_OR:   alu_uop = UOP_OR;
            default: alu_uop = UOP_AND;
        endcase
    endfunction

    // ----------------------------------------------------------------------
    // Field extraction
    assign opcode   = opcode_t'(instr[6:0]);
    assign funct3   = alu_f3_t'(instr[14:12]);
    assign funct7   = instr[31:25];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];                              // Immediate bits on OP-IMM
    assign imm_i    = {{(`FRV_XLEN-12){instr[31]}}, instr[31:20]}; // Sign extended
    assign imm_u    = {instr[31:12], 12'b0};
    assign shamt    = {{(`FRV_XLEN-5){1'b0}}, instr[24:20]};

    // ----------------------------------------------------------------------
    // Forwarding, execute first, then writeback, then register file
    assign hzd_rs1_s2 = (rs1_addr == fwd_s2_rd) && (rs1_addr != '0);
    assign hzd_rs1_wb = gpr_wen && (rs1_addr == gpr_rd) && (rs1_addr != '0);
    assign hzd_rs2_s2 = (rs2_addr == fwd_s2_rd) && (rs2_addr != '0);
    assign hzd_rs2_wb = gpr_wen && (rs2_addr == gpr_rd) && (rs2_addr != '0);

    assign fwd_rs1_rdata = hzd_rs1_s2 ? fwd_s2_wdata :
                           hzd_rs1_wb ? gpr_wdata    : rs1_rdata;
    assign fwd_rs2_rdata = hzd_rs2_s2 ? fwd_s2_wdata :
                           hzd_rs2_wb ? gpr_wdata    : rs2_rdata;

    // ----------------------------------------------------------------------
    // Decode and legality
    always_comb begin
        dec_uop   = UOP_ADD;
        dec_opr_b = fwd_rs2_rdata;
        dec_legal = 1'b0;
        case (opcode)
            OPC_OP_IMM: begin
                dec_uop = alu_uop(funct3, funct7[5] && funct3 == F3_SR);
                if (funct3 == F3_SLL || funct3 == F3_SR) begin
                    dec_opr_b = shamt;
                    dec_legal = funct7 == F7_BASE || (funct3 == F3_SR && funct7 == F7_ALT);
                end else begin
                    dec_opr_b = imm_i;
                    dec_legal = 1'b1;
                end
            end
            OPC_OP: begin
                dec_uop   = alu_uop(funct3, funct7[5]);
                dec_legal = funct7 == F7_BASE ||
                            (funct7 == F7_ALT && (funct3 == F3_ADD || funct3 == F3_SR));
            end
            OPC_LUI: begin
                dec_uop   = UOP_PASS_B;
                dec_opr_b = imm_u;
                dec_legal = 1'b1;
            end
            default: dec_legal = 1'b0;  // Anything else traps
        endcase
    end

    // ----------------------------------------------------------------------
    // Decode-to-execute register
    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            s2.valid <= 1'b0;
        end else begin
            s2.valid <= instr_valid;
        end
    end

    always_ff @(posedge g_clk) begin
        if (instr_valid) begin
            s2.rd    <= dec_legal ? instr[11:7] : '0;  // No write on trap
            s2.opr_a <= fwd_rs1_rdata;
            s2.opr_b <= dec_opr_b;
            s2.uop   <= dec_uop;
            s2.trap  <= !dec_legal;
            s2.instr <= instr;
        end
    end

    a_instr_known: assert property (@(posedge g_clk) disable iff (!rst_n)
        instr_valid |-> !$isunknown(instr))
        else $error("Unknown instruction word while instr_valid is high");

endmodule

// ==== source/frv_gprs.sv ====
//--------------------------------------------------------------------------
// General register file
// Two combinational read ports, one write port, x0 tied to zero
//--------------------------------------------------------------------------

`timescale 1ns/1ps
`include "frv_cfg.svh"

module frv_gprs (
    input  logic                    g_clk,
    input  logic                    rst_n,
    input  frv_pipe_pkg::reg_addr_t rs1_addr,  // Read port 1
    output frv_pipe_pkg::xword_t    rs1_data,
    input  frv_pipe_pkg::reg_addr_t rs2_addr,  // Read port 2
    output frv_pipe_pkg::xword_t    rs2_data,
    input  logic                    rd_wen,    // Write port
    input  frv_pipe_pkg::reg_addr_t rd_addr,
    input  frv_pipe_pkg::xword_t    rd_data
);
    import frv_pipe_pkg::*;

    xword_t regs [1:`FRV_NUM_GPRS-1];  // x1..x31, no storage for x0

    always_ff @(posedge g_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `FRV_NUM_GPRS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_addr != '0) begin
            regs[rd_addr] <= rd_data;  // Takes effect at the edge
        end
    end

    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];  // x0 reads zero
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Writeback must never present a write to x0
    a_no_x0_write: assert property (@(posedge g_clk) disable iff (!rst_n)
        rd_wen |-> rd_addr != '0)
        else $error("GPR write to x0");

endmodule

// ==== source/frv_stage_if.sv ====
//--------------------------------------------------------------------------
// Stage interfaces
// frv_s2_if: decode to execute, frv_s3_if: execute to writeback
//--------------------------------------------------------------------------

`timescale 1ns/1ps

interface frv_s2_if;
    import frv_isa_pkg::*;
    import frv_pipe_pkg::*;

    logic      valid;  // Stage holds an instruction
    reg_addr_t rd;     // Destination, zero on trap
    xword_t    opr_a;  // Forwarded rs1 value
    xword_t    opr_b;  // rs2 value or immediate
    uop_t      uop;    // ALU function
    logic      trap;   // Illegal instruction
    instr_t    instr;  // Word kept for the trace

    modport src (output valid, rd, opr_a, opr_b, uop, trap, instr);
    modport dst (input  valid, rd, opr_a, opr_b, uop, trap, instr);
endinterface

interface frv_s3_if;
    import frv_isa_pkg::*;
    import frv_pipe_pkg::*;

    logic      valid;   // Stage holds an instruction
    reg_addr_t rd;      // Destination, zero on trap
    xword_t    result;  // ALU result
    logic      trap;    // Illegal instruction
    instr_t    instr;   // Word kept for the trace

    modport src (output valid, rd, result, trap, instr);
    modport dst (input  valid, rd, result, trap, instr);
endinterface

// ==== source/frv_pipe_pkg.sv ====
//--------------------------------------------------------------------------
// Internal pipeline types: micro-ops, data words, register addresses
//--------------------------------------------------------------------------

package frv_pipe_pkg;

`include "frv_cfg.svh"

    // ALU micro-op carried from decode to execute
    typedef enum logic [3:0] {
        UOP_ADD,
        UOP_SUB,
        UOP_SLL,
        UOP_SLT,     // Signed compare
        UOP_SLTU,    // Unsigned compare
        UOP_XOR,
        UOP_SRL,
        UOP_SRA,     // Arithmetic shift
        UOP_OR,
        UOP_AND,
        UOP_PASS_B   // Operand B straight through, for LUI
    } uop_t;

    typedef logic [`FRV_XLEN-1:0]   xword_t;     // Data word
    typedef logic [`FRV_REG_AW-1:0] reg_addr_t;  // GPR address

endpackage

// ==== source/frv_isa_pkg.sv ====
//--------------------------------------------------------------------------
// RISC-V encoding types
// Major opcodes, ALU funct3 codes and the raw instruction word
//--------------------------------------------------------------------------

package frv_isa_pkg;

`include "frv_cfg.svh"

    // Major opcode field, instr[6:0]
    typedef enum logic [6:0] {
        OPC_OP_IMM = 7'b0010011,  // Register-immediate ALU
        OPC_OP     = 7'b0110011,  // Register-register ALU
        OPC_LUI    = 7'b0110111   // Load upper immediate
    } opcode_t;

    // ALU funct3 field, instr[14:12]
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,  // add / sub / addi
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SR   = 3'b101,  // srl / sra, split by funct7
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } alu_f3_t;

    typedef logic [`FRV_ILEN-1:0] instr_t;  // Raw instruction word

endpackage

// ==== source/frv_cfg.svh ====
//--------------------------------------------------------------------------
// Core width macros: data word, instruction word, register file size
//--------------------------------------------------------------------------

`ifndef FRV_CFG_SVH
`define FRV_CFG_SVH

`define FRV_XLEN      32  // Data word width
`define FRV_ILEN      32  // Instruction word width
`define FRV_NUM_GPRS  32  // General registers, x0 included
`define FRV_REG_AW    5   // Register address width

`endif
